/* design/i2c_cfg.svh */
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// Core clock cycles per quarter of one SCL period
`define I2C_QTR_DIV    4

// Entries in each byte FIFO
`define I2C_FIFO_DEPTH 8

// Byte count width, up to 15 bytes per transaction
`define I2C_CNT_W      4

`endif

/* design/i2c_bus_pkg.sv */
package i2c_bus_pkg;

    // Bus sequencer states
    typedef enum logic [3:0] {
        IDLE,        // Lines released, waiting for start
        START,       // SDA falls while SCL high
        ADDRESS,     // 7-bit address plus R/W, MSB first
        ADDR_ACK,    // Target acknowledges address
        WRITE_DATA,  // Byte out, MSB first
        DATA_ACK,    // Target acknowledges written byte
        READ_DATA,   // Byte in, MSB first
        MASTER_ACK,  // ACK, or NACK on last byte
        STOP         // SDA rises while SCL high
    } bus_state_t;

    typedef logic [2:0] bit_idx_t;  // Bit position 7 down to 0

endpackage

/* design/i2c_host_pkg.sv */
`include "i2c_cfg.svh"

package i2c_host_pkg;

    // Transfer direction, same value as the R/W bit on the bus
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } i2c_dir_t;

    // Completion status returned with cmd_ack
    typedef enum logic [1:0] {
        ST_OK        = 2'd0,  // All bytes moved
        ST_ADDR_NACK = 2'd1,  // Nobody answered the address
        ST_DATA_NACK = 2'd2   // Target refused a written byte
    } i2c_status_t;

    typedef logic [`I2C_CNT_W-1:0] byte_count_t;  // Requested or moved bytes

endpackage

/* design/i2c_scl_timer.sv */
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_scl_timer (
    input  logic       i2c_clk,
    input  logic       rst,
    input  logic       run,    // Low keeps the divider cleared
    input  logic       hold,   // Freeze count and phase
    output logic       tick,   // One cycle per quarter period
    output logic [1:0] phase   // Quarter within the SCL bit
);

    localparam int DIV   = `I2C_QTR_DIV;
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CNT_W-1:0] cnt;  // Cycles inside current quarter

    assign tick = run && !hold && (cnt == CNT_W'(DIV - 1));  // Last cycle of quarter

    always_ff @(posedge i2c_clk or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            phase <= 2'd0;
        end else if (!run) begin
            cnt   <= '0;  // Every transfer starts at quarter 0
            phase <= 2'd0;
        end else if (!hold) begin
            if (tick) begin
                cnt   <= '0;
                phase <= phase + 2'd1;  // Wraps after quarter 3
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* design/i2c_byte_fifo.sv */
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_byte_fifo #(
    parameter int DEPTH = `I2C_FIFO_DEPTH
) (
    input  logic       i2c_clk,
    input  logic       rst,
    input  logic       push,
    input  logic       pop,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,  // Head entry, valid while not empty
    output logic       full,
    output logic       empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // Overflow dropped
    assign do_pop  = pop && !empty;   // Underflow ignored
    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign rdata   = mem[rd_ptr];     // First-word fall-through

    always_ff @(posedge i2c_clk) begin
        if (do_push) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge i2c_clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    a_no_overflow: assert property (@(posedge i2c_clk) disable iff (rst) !(push && full))
        else $error("push into full FIFO");
    a_no_underflow: assert property (@(posedge i2c_clk) disable iff (rst) !(pop && empty))
        else $error("pop from empty FIFO");

endmodule

/* design/i2c_host_port.sv */
`timescale 1ns/100ps

module i2c_host_port
    import i2c_host_pkg::*;
(
    input  logic        i2c_clk,
    input  logic        rst,
    input  logic        cmd_req,
    input  logic [6:0]  cmd_addr,
    input  i2c_dir_t    cmd_dir,
    input  byte_count_t cmd_len,
    input  logic        done,         // Engine finished, one cycle
    input  i2c_status_t done_status,
    input  byte_count_t done_xfer,
    output logic        cmd_ack,
    output i2c_status_t cmd_status,
    output byte_count_t cmd_xfer,
    output logic        start,        // One-cycle kick to engine
    output logic [6:0]  xfer_addr,
    output i2c_dir_t    xfer_dir,
    output byte_count_t xfer_len
);

    typedef enum logic [1:0] {
        P_WAIT,  // Idle, ack low
        P_BUSY,  // Engine running
        P_ACK    // Result shown until req drops
    } port_state_t;

    port_state_t state;

    always_ff @(posedge i2c_clk or posedge rst) begin
        if (rst) begin
            state   <= P_WAIT;
            start   <= 1'b0;
            cmd_ack <= 1'b0;
        end else begin
            start <= 1'b0;  // Pulse only
            case (state)
                P_WAIT: begin
                    if (cmd_req) begin
                        start <= 1'b1;
                        state <= P_BUSY;
                    end
                end
                P_BUSY: begin
                    if (done) begin
                        cmd_ack <= 1'b1;  // Cycle after done
                        state   <= P_ACK;
                    end
                end
                P_ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;  // Four-phase return to zero
                        state   <= P_WAIT;
                    end
                end
                default: state <= P_WAIT;
            endcase
        end
    end

    // Transaction and result latches
    always_ff @(posedge i2c_clk) begin
        if (state == P_WAIT && cmd_req) begin
            xfer_addr <= cmd_addr;
            xfer_dir  <= cmd_dir;
            xfer_len  <= cmd_len;
        end
        if (state == P_BUSY && done) begin
            cmd_status <= done_status;
            cmd_xfer   <= done_xfer;
        end
    end

    // Host must keep the command still until it sees ack
    a_cmd_stable: assert property (@(posedge i2c_clk) disable iff (rst)
        (cmd_req && !cmd_ack && $past(cmd_req) && !$past(cmd_ack))
            |-> $stable({cmd_addr, cmd_dir, cmd_len}))
        else $error("command fields changed during request");

endmodule

/* design/i2c_bit_engine.sv */
`timescale 1ns/100ps

module i2c_bit_engine
    import i2c_bus_pkg::*, i2c_host_pkg::*;
(
    input  logic        i2c_clk,
    input  logic        rst,
    input  logic        start,
    input  logic [6:0]  xfer_addr,
    input  i2c_dir_t    xfer_dir,
    input  byte_count_t xfer_len,
    input  logic        tick,         // Quarter boundary from timer
    input  logic [1:0]  phase,        // Quarter ending on this tick
    input  logic [7:0]  tx_byte,      // Transmit FIFO head
    input  logic        tx_empty,
    input  logic        rx_full,
    input  logic        scl_in,       // Pin readback
    input  logic        sda_in,
    output logic        run,
    output logic        hold,
    output logic        tx_pop,
    output logic        rx_push,
    output logic [7:0]  rx_byte,
    output logic        scl_low,      // Open-drain pull enables
    output logic        sda_low,
    output logic        done,
    output i2c_status_t done_status,
    output byte_count_t done_xfer
);

    bus_state_t  state;
    bit_idx_t    bit_idx;
    logic [7:0]  shreg;      // Address, write or read byte
    byte_count_t xfer_cnt;   // Bytes acknowledged so far
    byte_count_t cnt_next;
    i2c_status_t status;
    logic        acked;      // Sampled ACK bit
    logic        q0, q1, q2, q3;

    // Quarter strobes; SCL low in 0-1, high in 2-3
    assign q0 = tick && (phase == 2'd0);
    assign q1 = tick && (phase == 2'd1);
    assign q2 = tick && (phase == 2'd2);
    assign q3 = tick && (phase == 2'd3);

    assign cnt_next = xfer_cnt + 1'b1;
    assign run      = (state != IDLE);

    // Stall in quarter 0 with SCL already low
    assign hold = (phase == 2'd0) &&
                  ((state == WRITE_DATA && bit_idx == 3'd7 && tx_empty) ||
                   (state == MASTER_ACK && rx_full));

    assign tx_pop      = q0 && (state == WRITE_DATA) && (bit_idx == 3'd7);  // Fetch at MSB
    assign rx_push     = q0 && (state == MASTER_ACK);                        // Byte complete
    assign rx_byte     = shreg;
    assign done_status = status;
    assign done_xfer   = xfer_cnt;

    always_ff @(posedge i2c_clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            bit_idx  <= 3'd7;
            shreg    <= 8'h00;
            xfer_cnt <= '0;
            status   <= ST_OK;
            acked    <= 1'b0;
            scl_low  <= 1'b0;
            sda_low  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (q1) scl_low <= 1'b0;                    // SCL rises
            if (q3 && state != STOP) scl_low <= 1'b1;   // SCL falls, STOP leaves it high
            case (state)
                IDLE: begin
                    if (start) begin
                        shreg    <= {xfer_addr, xfer_dir};
                        xfer_cnt <= '0;
                        status   <= ST_OK;
                        state    <= START;
                    end
                end
                START: begin
                    if (q1) sda_low <= 1'b1;  // START condition
                    if (q3) begin
                        bit_idx <= 3'd7;
                        state   <= ADDRESS;
                    end
                end
                ADDRESS: begin
                    if (q0) sda_low <= ~shreg[bit_idx];
                    if (q3) begin
                        if (bit_idx == 3'd0) state <= ADDR_ACK;
                        else bit_idx <= bit_idx - 1'b1;
                    end
                end
                ADDR_ACK: begin
                    if (q0) sda_low <= 1'b0;     // Let target drive
                    if (q2) acked <= ~sda_in;
                    if (q3) begin
                        bit_idx <= 3'd7;
                        if (!acked) begin
                            status <= ST_ADDR_NACK;
                            state  <= STOP;
                        end else if (xfer_len == '0) begin
                            state <= STOP;        // Address-only probe
                        end else if (xfer_dir == DIR_READ) begin
                            state <= READ_DATA;
                        end else begin
                            state <= WRITE_DATA;
                        end
                    end
                end
                WRITE_DATA: begin
                    if (q0) begin
                        if (bit_idx == 3'd7) begin
                            shreg   <= tx_byte;   // Popped this cycle
                            sda_low <= ~tx_byte[7];
                        end else begin
                            sda_low <= ~shreg[bit_idx];
                        end
                    end
                    if (q3) begin
                        if (bit_idx == 3'd0) state <= DATA_ACK;
                        else bit_idx <= bit_idx - 1'b1;
                    end
                end
                DATA_ACK: begin
                    if (q0) sda_low <= 1'b0;
                    if (q2) acked <= ~sda_in;
                    if (q3) begin
                        bit_idx <= 3'd7;
                        if (!acked) begin
                            status <= ST_DATA_NACK;  // Refused byte not counted
                            state  <= STOP;
                        end else begin
                            xfer_cnt <= cnt_next;
                            state    <= (cnt_next == xfer_len) ? STOP : WRITE_DATA;
                        end
                    end
                end
                READ_DATA: begin
                    if (q0) sda_low <= 1'b0;
                    if (q2) shreg[bit_idx] <= sda_in;  // MSB arrives first
                    if (q3) begin
                        if (bit_idx == 3'd0) state <= MASTER_ACK;
                        else bit_idx <= bit_idx - 1'b1;
                    end
                end
                MASTER_ACK: begin
                    if (q0) begin
                        sda_low  <= (cnt_next != xfer_len);  // NACK on last byte
                        xfer_cnt <= cnt_next;
                    end
                    if (q3) begin
                        bit_idx <= 3'd7;
                        state   <= (xfer_cnt == xfer_len) ? STOP : READ_DATA;
                    end
                end
                STOP: begin
                    if (q0) sda_low <= 1'b1;  // SDA low under SCL low
                    if (q2) sda_low <= 1'b0;  // STOP condition
                    if (q3) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data on the wire (ours or the target's) only moves under SCL high for START/STOP
    a_sda_stable_scl_high: assert property (@(posedge i2c_clk) disable iff (rst)
        (scl_in && $past(scl_in) && (sda_in != $past(sda_in)))
            |-> ($past(state) inside {START, STOP}))
        else $error("SDA changed while SCL high");

endmodule

/* design/i2c_master_top.sv */
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_master_top
    import i2c_host_pkg::*;
(
    input  logic        i2c_clk,
    input  logic        rst,
    input  logic        cmd_req,
    input  logic [6:0]  cmd_addr,
    input  i2c_dir_t    cmd_dir,
    input  byte_count_t cmd_len,
    input  logic        tx_push,
    input  logic [7:0]  tx_byte,
    input  logic        rx_pop,
    output logic        cmd_ack,
    output i2c_status_t cmd_status,
    output byte_count_t cmd_xfer,
    output logic        tx_full,
    output logic [7:0]  rx_byte,
    output logic        rx_empty,
    inout  wire         i2c_scl,
    inout  wire         i2c_sda
);

    logic        start;
    logic [6:0]  xfer_addr;
    i2c_dir_t    xfer_dir;
    byte_count_t xfer_len;
    logic        done;
    i2c_status_t done_status;
    byte_count_t done_xfer;
    logic        run;
    logic        hold;
    logic        tick;
    logic [1:0]  phase;
    logic [7:0]  tx_head;   // Next byte for the bus
    logic        tx_empty;
    logic        tx_pop;
    logic [7:0]  rx_data;   // Byte from the bus
    logic        rx_full;
    logic        rx_push;
    logic        scl_low;
    logic        sda_low;

    // Open-drain drivers, pull-ups are external
    assign i2c_scl = scl_low ? 1'b0 : 1'bz;
    assign i2c_sda = sda_low ? 1'b0 : 1'bz;

    i2c_host_port i_port (
        .i2c_clk, .rst, .cmd_req, .cmd_addr, .cmd_dir, .cmd_len,
        .done, .done_status, .done_xfer,
        .cmd_ack, .cmd_status, .cmd_xfer,
        .start, .xfer_addr, .xfer_dir, .xfer_len
    );

    i2c_scl_timer i_timer (
        .i2c_clk, .rst, .run, .hold, .tick, .phase
    );

    i2c_bit_engine i_engine (
        .i2c_clk, .rst, .start, .xfer_addr, .xfer_dir, .xfer_len,
        .tick, .phase,
        .tx_byte (tx_head),
        .tx_empty, .rx_full,
        .scl_in  (i2c_scl),
        .sda_in  (i2c_sda),
        .run, .hold, .tx_pop, .rx_push,
        .rx_byte (rx_data),
        .scl_low, .sda_low, .done, .done_status, .done_xfer
    );

    i2c_byte_fifo #(.DEPTH(`I2C_FIFO_DEPTH)) i_tx_fifo (
        .i2c_clk, .rst,
        .push  (tx_push),
        .pop   (tx_pop),
        .wdata (tx_byte),
        .rdata (tx_head),
        .full  (tx_full),
        .empty (tx_empty)
    );

    i2c_byte_fifo #(.DEPTH(`I2C_FIFO_DEPTH)) i_rx_fifo (
        .i2c_clk, .rst,
        .push  (rx_push),
        .pop   (rx_pop),
        .wdata (rx_data),
        .rdata (rx_byte),
        .full  (rx_full),
        .empty (rx_empty)
    );

endmodule

/* sim/i2c_target_model.sv */
`timescale 1ns/100ps

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  wire scl,
    inout  wire sda
);

    typedef enum logic [2:0] {
        M_IDLE,   // Bus free
        M_ADDR,   // Address byte coming in
        M_WRITE,  // Master writes memory
        M_READ,   // Master reads memory
        M_WAIT    // Not addressed or done, ignore until START/STOP
    } mode_t;

    logic [7:0] mem [4];     // Target storage, checked by the testbench
    mode_t      mode;
    logic       sda_low;     // Open-drain pull on SDA
    logic       scl_q;       // Line levels before this event
    logic       sda_q;
    logic       ack_slot;    // Ninth clock of the byte
    logic       master_ack;  // Master wants another read byte
    logic [3:0] bit_cnt;     // Bits seen on rising SCL
    logic [7:0] shreg;
    logic [7:0] rd_byte;     // Byte being sent to master
    logic [1:0] ptr;         // Memory pointer, wraps at four
    int         wr_cnt;      // Bytes accepted since START

    assign sda = sda_low ? 1'b0 : 1'bz;

    // START seen, new frame
    task reset_frame();
        mode     = M_ADDR;
        bit_cnt  = 4'd0;
        ptr      = 2'd0;  // Pointer restarts every frame
        wr_cnt   = 0;
        ack_slot = 1'b0;
        sda_low  = 1'b0;
    endtask

    // STOP seen
    task release_bus();
        mode     = M_IDLE;
        ack_slot = 1'b0;
        sda_low  = 1'b0;
    endtask

    // Rising SCL, data is stable here
    task take_bit();
        if (mode != M_IDLE && mode != M_WAIT) begin
            if (ack_slot) begin
                master_ack = (sda === 1'b0);
            end else begin
                shreg   = {shreg[6:0], (sda === 1'b1)};
                bit_cnt = bit_cnt + 4'd1;
            end
        end
    endtask

    // Falling SCL, all changes on SDA happen here
    task advance_bit();
        if (ack_slot) begin
            ack_slot = 1'b0;
            sda_low  = 1'b0;  // End of ACK bit
            if (mode == M_READ) begin
                if (master_ack) begin
                    rd_byte = mem[ptr];
                    ptr     = ptr + 2'd1;
                    sda_low = ~rd_byte[7];  // MSB of next byte
                end else begin
                    mode = M_WAIT;  // NACK ends the read
                end
            end
        end else if (bit_cnt == 4'd8) begin
            bit_cnt  = 4'd0;
            ack_slot = 1'b1;
            case (mode)
                M_ADDR: begin
                    if (shreg[7:1] == ADDR) begin
                        sda_low    = 1'b1;
                        master_ack = 1'b1;  // Address ACK leads into first read byte
                        mode       = shreg[0] ? M_READ : M_WRITE;
                    end else begin
                        mode = M_WAIT;      // Someone else's address
                    end
                end
                M_WRITE: begin
                    if (wr_cnt < 4) begin
                        mem[ptr] = shreg;
                        ptr      = ptr + 2'd1;
                        wr_cnt   = wr_cnt + 1;
                        sda_low  = 1'b1;
                    end else begin
                        mode = M_WAIT;      // Fifth byte refused
                    end
                end
                M_READ:  sda_low = 1'b0;    // Master drives its ACK
                default: sda_low = 1'b0;
            endcase
        end else if (mode == M_READ) begin
            sda_low = ~rd_byte[4'd7 - bit_cnt];
        end
    endtask

    initial begin
        foreach (mem[i]) mem[i] = 8'h00;
        mode       = M_IDLE;
        sda_low    = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        ack_slot   = 1'b0;
        master_ack = 1'b0;
        bit_cnt    = 4'd0;
        shreg      = 8'h00;
        rd_byte    = 8'h00;
        ptr        = 2'd0;
        wr_cnt     = 0;
        forever begin
            @(scl or sda);
            if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
                reset_frame();
            else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
                release_bus();
            else if (scl_q === 1'b0 && scl === 1'b1)
                take_bit();
            else if (scl_q === 1'b1 && scl === 1'b0)
                advance_bit();
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

/* sim/tb_i2c_master.sv */
`timescale 1ns/100ps

module tb_i2c_master
    import i2c_host_pkg::*;
();

    localparam int          WAIT_LIMIT  = 5000;          // Cycles per wait loop
    localparam logic [6:0]  TARGET_ADDR = 7'h50;
    localparam logic [6:0]  GHOST_ADDR  = 7'h23;         // Nobody answers here
    localparam logic [31:0] SEED        = 32'h8a4949d4;

    logic        i2c_clk;
    logic        rst;
    logic        cmd_req;
    logic [6:0]  cmd_addr;
    i2c_dir_t    cmd_dir;
    byte_count_t cmd_len;
    logic        tx_push;
    logic [7:0]  tx_byte;
    logic        rx_pop;
    logic        cmd_ack;
    i2c_status_t cmd_status;
    byte_count_t cmd_xfer;
    logic        tx_full;
    logic [7:0]  rx_byte;
    logic        rx_empty;
    wire         i2c_scl;
    wire         i2c_sda;

    logic [7:0]  exp_mem [4];   // Expected target memory
    logic [7:0]  tx_model [$];  // Bytes in the transmit FIFO, oldest first

    pullup (i2c_scl);
    pullup (i2c_sda);

    i2c_master_top i_dut (
        .i2c_clk, .rst, .cmd_req, .cmd_addr, .cmd_dir, .cmd_len,
        .tx_push, .tx_byte, .rx_pop,
        .cmd_ack, .cmd_status, .cmd_xfer, .tx_full, .rx_byte, .rx_empty,
        .i2c_scl, .i2c_sda
    );

    i2c_target_model #(.ADDR(TARGET_ADDR)) i_target (
        .scl (i2c_scl),
        .sda (i2c_sda)
    );

    initial begin
        i2c_clk = 1'b0;
        forever #2 i2c_clk = ~i2c_clk;  // 4 ns period
    end

    task automatic next_cycle();
        @(posedge i2c_clk);
        #1;  // Drive and sample away from the edge
    endtask

    task automatic abort_run(string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_status(string name, i2c_status_t got, i2c_status_t exp);
        if (got !== exp) abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_count(string name, byte_count_t got, byte_count_t exp);
        if (got !== exp) abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic wait_for_ack(logic level);
        int n;
        n = 0;
        while (cmd_ack !== level) begin
            if (n == WAIT_LIMIT)
                abort_run($sformatf("cmd_ack did not go to %0d within %0d cycles", level, n));
            next_cycle();
            n++;
        end
    endtask

    // Four-phase request, fields held until ack
    task automatic issue_cmd(logic [6:0] addr, i2c_dir_t dir, byte_count_t len);
        wait_for_ack(1'b0);
        cmd_addr = addr;
        cmd_dir  = dir;
        cmd_len  = len;
        cmd_req  = 1'b1;
    endtask

    task automatic complete_cmd(output i2c_status_t st, output byte_count_t n);
        wait_for_ack(1'b1);
        st      = cmd_status;
        n       = cmd_xfer;
        cmd_req = 1'b0;
        wait_for_ack(1'b0);  // Return to zero
    endtask

    task automatic push_tx(logic [7:0] b);
        int n;
        n = 0;
        while (tx_full) begin
            if (n == WAIT_LIMIT) abort_run("transmit FIFO stayed full");
            next_cycle();
            n++;
        end
        tx_byte = b;
        tx_push = 1'b1;
        next_cycle();
        tx_push = 1'b0;
    endtask

    task automatic load_tx(int count);
        logic [7:0] b;
        for (int i = 0; i < count; i++) begin
            b = 8'($urandom);
            tx_model.push_back(b);
            push_tx(b);
        end
    endtask

    task automatic pop_rx(output logic [7:0] b);
        int n;
        n = 0;
        while (rx_empty) begin
            if (n == WAIT_LIMIT) abort_run("no byte arrived in the receive FIFO");
            next_cycle();
            n++;
        end
        b      = rx_byte;  // Head is visible before the pop
        rx_pop = 1'b1;
        next_cycle();
        rx_pop = 1'b0;
    endtask

    // Acked bytes land in target memory from 0, a refused byte still left the FIFO
    task automatic account_write(i2c_status_t st, byte_count_t n);
        if (st != ST_ADDR_NACK) begin
            for (int i = 0; i < int'(n); i++) exp_mem[i % 4] = tx_model.pop_front();
            if (st == ST_DATA_NACK) void'(tx_model.pop_front());
        end
    endtask

    task automatic check_target_mem();
        for (int i = 0; i < 4; i++)
            check_byte($sformatf("target mem[%0d]", i), i_target.mem[i], exp_mem[i]);
    endtask

    task automatic write_bytes(logic [6:0] addr, byte_count_t len,
                               i2c_status_t exp_st, byte_count_t exp_n);
        i2c_status_t st;
        byte_count_t n;
        issue_cmd(addr, DIR_WRITE, len);
        complete_cmd(st, n);
        check_status("cmd_status", st, exp_st);
        check_count("cmd_xfer", n, exp_n);
        account_write(exp_st, exp_n);
        check_target_mem();
    endtask

    // Transfer must sit with SCL low and no ack
    task automatic expect_stall(int cycles);
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            if (cmd_ack) abort_run("transfer finished while it should be stalled");
        end
        check_flag("i2c_scl", i2c_scl, 1'b0);
    endtask

    task automatic test_idle_after_reset();
        check_flag("cmd_ack", cmd_ack, 1'b0);
        check_flag("rx_empty", rx_empty, 1'b1);
        check_flag("tx_full", tx_full, 1'b0);
        check_flag("i2c_scl", i2c_scl, 1'b1);  // Both lines released
        check_flag("i2c_sda", i2c_sda, 1'b1);
    endtask

    task automatic test_write_three();
        load_tx(3);
        write_bytes(TARGET_ADDR, byte_count_t'(3), ST_OK, byte_count_t'(3));
    endtask

    task automatic test_read_back();
        i2c_status_t st;
        byte_count_t n;
        logic [7:0]  b;
        issue_cmd(TARGET_ADDR, DIR_READ, byte_count_t'(3));
        complete_cmd(st, n);
        check_status("cmd_status", st, ST_OK);
        check_count("cmd_xfer", n, byte_count_t'(3));
        for (int i = 0; i < 3; i++) begin
            pop_rx(b);
            check_byte($sformatf("rx byte %0d", i), b, exp_mem[i]);
        end
        check_flag("rx_empty", rx_empty, 1'b1);
    endtask

    task automatic test_addr_nack();
        load_tx(8);
        check_flag("tx_full", tx_full, 1'b1);
        write_bytes(GHOST_ADDR, byte_count_t'(8), ST_ADDR_NACK, byte_count_t'(0));
        check_flag("tx_full", tx_full, 1'b1);  // Nothing consumed
        write_bytes(TARGET_ADDR, byte_count_t'(4), ST_OK, byte_count_t'(4));
        check_flag("tx_full", tx_full, 1'b0);
        write_bytes(TARGET_ADDR, byte_count_t'(4), ST_OK, byte_count_t'(4));
    endtask

    task automatic test_data_nack();
        load_tx(5);
        write_bytes(TARGET_ADDR, byte_count_t'(5), ST_DATA_NACK, byte_count_t'(4));
    endtask

    task automatic test_tx_underrun();
        i2c_status_t st;
        byte_count_t n;
        load_tx(1);
        issue_cmd(TARGET_ADDR, DIR_WRITE, byte_count_t'(2));
        expect_stall(800);  // Waiting for the second byte
        load_tx(1);
        complete_cmd(st, n);
        check_status("cmd_status", st, ST_OK);
        check_count("cmd_xfer", n, byte_count_t'(2));
        account_write(ST_OK, byte_count_t'(2));
        check_target_mem();
    endtask

    task automatic test_rx_full();
        i2c_status_t st;
        byte_count_t n;
        logic [7:0]  b;
        issue_cmd(TARGET_ADDR, DIR_READ, byte_count_t'(10));
        expect_stall(2500);  // Ninth byte has no room
        check_flag("rx_empty", rx_empty, 1'b0);
        for (int i = 0; i < 10; i++) begin
            pop_rx(b);
            check_byte($sformatf("rx byte %0d", i), b, exp_mem[i % 4]);  // Reads wrap
        end
        complete_cmd(st, n);
        check_status("cmd_status", st, ST_OK);
        check_count("cmd_xfer", n, byte_count_t'(10));
        check_flag("rx_empty", rx_empty, 1'b1);
    endtask

    initial begin
        rst      = 1'b1;
        cmd_req  = 1'b0;
        cmd_addr = 7'h00;
        cmd_dir  = DIR_WRITE;
        cmd_len  = '0;
        tx_push  = 1'b0;
        tx_byte  = 8'h00;
        rx_pop   = 1'b0;
        foreach (exp_mem[i]) exp_mem[i] = 8'h00;  // Target memory starts cleared
        void'($urandom(SEED));
        repeat (2) @(posedge i2c_clk);
        #1 rst = 1'b0;
        next_cycle();
        test_idle_after_reset();
        test_write_three();
        test_read_back();
        test_addr_nack();
        test_data_nack();
        test_tx_underrun();
        test_rx_full();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/i2c_bus_pkg.sv
design/i2c_host_pkg.sv
design/i2c_scl_timer.sv
design/i2c_byte_fifo.sv
design/i2c_host_port.sv
design/i2c_bit_engine.sv
design/i2c_master_top.sv
sim/i2c_target_model.sv
sim/tb_i2c_master.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the I2C master testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_i2c_master -o tb_i2c_master > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_i2c_master > sim.log 2>&1
run_status=$?

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status, see sim.log"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
